/* sifh_params.svh */
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// sample and bin geometry
`define SIFH_NP        8   // sample width
`define SIFH_NB        4   // bin index width

// stream shape
`define SIFH_DATA_NUM  8   // samples per pixel
`define SIFH_PIXEL_NUM 4   // pixels per frame

// counter width of one bin
`define SIFH_COUNT_W   4

`endif

/* sifhHistoPkg.sv */
`include "sifh_params.svh"

package sifhHistoPkg;

    typedef logic [`SIFH_NP-1:0]                  sampleT;
    typedef logic [`SIFH_NB-1:0]                  binIdxT;
    typedef logic [`SIFH_COUNT_W-1:0]             countT;
    typedef logic [$clog2(`SIFH_PIXEL_NUM)-1:0]   pixelIdxT;

    // one sample as offered to a bank
    typedef struct packed {
        pixelIdxT pixel;
        binIdxT   bin;
        logic     keep;          // sample lies in the window
        logic     lastOfPixel;
        sampleT   sample;        // raw value, used by the fine path
    } binEventT;

    typedef struct packed {
        pixelIdxT pixel;
        binIdxT   bin;
        countT    count;
    } peakT;

endpackage

/* sifhStreamPkg.sv */
package sifhStreamPkg;
    import sifhHistoPkg::*;

    typedef struct packed {
        sampleT value;
    } sampleInT;

    // refined result of one pixel
    typedef struct packed {
        pixelIdxT pixel;
        binIdxT   coarseBin;
        countT    coarseCount;
        binIdxT   fineBin;
        countT    fineCount;
        sampleT   windowLow;     // fine window used for this frame
        sampleT   position;
    } resultT;

endpackage

/* sampleSequencer.sv */
`timescale 1ns/1ps
`include "sifh_params.svh"

module sampleSequencer import sifhHistoPkg::*, sifhStreamPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  sampleInT in,
    input  logic     inValid,
    output logic     inReady,
    input  logic     coarseReady,
    input  logic     fineReady,
    output binEventT coarseEvt,
    output binEventT fineRaw,
    output logic     evtValid
);

    localparam int CntW = $clog2(`SIFH_DATA_NUM);

    logic [CntW-1:0] sampleCnt;      // sample index inside the pixel
    pixelIdxT        pixelCnt;
    logic            started;        // holds inReady low right after reset
    logic            lastOfPixel;

    assign inReady     = started && coarseReady && fineReady;
    assign evtValid    = inValid && inReady;
    assign lastOfPixel = (sampleCnt == CntW'(`SIFH_DATA_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            started   <= 1'b0;
            sampleCnt <= '0;
            pixelCnt  <= '0;
        end else begin
            started <= 1'b1;
            if (evtValid) begin
                if (lastOfPixel) begin
                    sampleCnt <= '0;
                    pixelCnt  <= (pixelCnt == pixelIdxT'(`SIFH_PIXEL_NUM - 1)) ? '0
                                                                              : pixelCnt + 1'b1;
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        coarseEvt.pixel       = pixelCnt;
        coarseEvt.bin         = in.value[`SIFH_NP-1 -: `SIFH_NB];   // top bits only
        coarseEvt.keep        = 1'b1;
        coarseEvt.lastOfPixel = lastOfPixel;
        coarseEvt.sample      = in.value;

        fineRaw.pixel       = pixelCnt;
        fineRaw.bin         = '0;          // filled in by the mapper
        fineRaw.keep        = 1'b0;
        fineRaw.lastOfPixel = lastOfPixel;
        fineRaw.sample      = in.value;
    end

    // a waiting sample must not change or vanish before it is taken
    inHeldUntilTaken: assert property (@(posedge clk) disable iff (!combin_res)
        inValid && !inReady |=> inValid && $stable(in));

endmodule

/* fineWindowMapper.sv */
`timescale 1ns/1ps
`include "sifh_params.svh"

module fineWindowMapper import sifhHistoPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  binEventT fineRaw,
    output binEventT fineEvt,
    input  peakT     winUpdate,
    input  logic     winUpdValid,
    input  pixelIdxT winQueryPixel,
    output sampleT   queryLow
);

    localparam int Shift  = `SIFH_NP - `SIFH_NB;
    localparam int Half   = (1 << `SIFH_NB) / 2;
    localparam int MaxLow = (1 << `SIFH_NP) - (1 << `SIFH_NB);

    sampleT windowLow [`SIFH_PIXEL_NUM];
    sampleT curLow;
    sampleT offset;
    sampleT newLow;

    assign curLow   = windowLow[fineRaw.pixel];
    assign offset   = fineRaw.sample - curLow;
    assign queryLow = windowLow[winQueryPixel];   // value before any pending update

    always_comb begin
        fineEvt      = fineRaw;
        fineEvt.keep = (fineRaw.sample >= curLow) && (offset <= sampleT'((1 << `SIFH_NB) - 1));
        fineEvt.bin  = offset[`SIFH_NB-1:0];
    end

    // new window start from the coarse peak
    always_comb begin
        int centre;
        int start;
        centre = (int'(winUpdate.bin) << Shift) + Half;
        start  = centre - Half;
        if (start < 0) begin
            start = 0;
        end else if (start > MaxLow) begin
            start = MaxLow;
        end
        newLow = sampleT'(start);
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < `SIFH_PIXEL_NUM; i++) begin
                windowLow[i] <= '0;
            end
        end else if (winUpdValid) begin
            windowLow[winUpdate.pixel] <= newLow;
        end
    end

    // whole window stays inside the sample range
    windowInRange: assert property (@(posedge clk) disable iff (!combin_res)
        winUpdValid |=> windowLow[$past(winUpdate.pixel)] <= sampleT'(MaxLow));

endmodule

/* histogramBank.sv */
`timescale 1ns/1ps
`include "sifh_params.svh"

module histogramBank import sifhHistoPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  binEventT evt,
    input  logic     evtValid,
    output logic     ready,
    output peakT     peak,
    output logic     peakValid,
    input  logic     peakReady
);

    localparam int BinNum = 1 << `SIFH_NB;

    countT             binCount [BinNum];
    logic [BinNum-1:0] binValid;         // lazy clear per pixel
    binEventT          s1Evt;
    logic              s1Valid;
    countT             s1Count;          // count read at handshake
    countT             newCount;
    countT             maxCount;
    binIdxT            maxBin;
    logic              hold;
    logic              accept;
    logic              fwdHit;
    logic              newMax;

    // last sample waits while the previous peak is still unclaimed
    assign hold     = s1Valid && s1Evt.lastOfPixel && peakValid && !peakReady;
    assign ready    = !hold;
    assign accept   = evtValid && ready;
    assign newCount = s1Count + 1'b1;
    assign newMax   = s1Valid && s1Evt.keep && (newCount > maxCount);   // strict so first wins
    assign fwdHit   = s1Valid && s1Evt.keep && (s1Evt.bin == evt.bin);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1Valid <= 1'b0;
        end else if (!hold) begin
            s1Valid <= accept;
        end
    end

    // read stage with forwarding from the write stage
    always_ff @(posedge clk) begin
        if (accept) begin
            s1Evt <= evt;
            if (s1Valid && s1Evt.lastOfPixel) begin
                s1Count <= '0;             // new pixel starts empty
            end else if (fwdHit) begin
                s1Count <= newCount;
            end else if (binValid[evt.bin]) begin
                s1Count <= binCount[evt.bin];
            end else begin
                s1Count <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid && s1Evt.keep && !hold) begin
            binCount[s1Evt.bin] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid  <= '0;
            maxCount  <= '0;
            maxBin    <= '0;
            peakValid <= 1'b0;
        end else begin
            if (peakValid && peakReady) begin
                peakValid <= 1'b0;
            end
            if (s1Valid && !hold) begin
                if (s1Evt.lastOfPixel) begin
                    binValid  <= '0;
                    maxCount  <= '0;
                    maxBin    <= '0;
                    peakValid <= 1'b1;
                end else begin
                    if (s1Evt.keep) begin
                        binValid[s1Evt.bin] <= 1'b1;
                    end
                    if (newMax) begin
                        maxCount <= newCount;
                        maxBin   <= s1Evt.bin;
                    end
                end
            end
        end
    end

    // output slot takes in the last sample of the pixel
    always_ff @(posedge clk) begin
        if (s1Valid && !hold && s1Evt.lastOfPixel) begin
            peak.pixel <= s1Evt.pixel;
            peak.bin   <= newMax ? s1Evt.bin : maxBin;
            peak.count <= newMax ? newCount : maxCount;
        end
    end

    countNoWrap: assert property (@(posedge clk) disable iff (!combin_res)
        s1Valid && s1Evt.keep |-> s1Count != '1);

endmodule

/* peakCombiner.sv */
`timescale 1ns/1ps
`include "sifh_params.svh"

module peakCombiner import sifhHistoPkg::*, sifhStreamPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  peakT     coarsePeak,
    input  peakT     finePeak,
    input  logic     coarseValid,
    input  logic     fineValid,
    output logic     peakReady,
    output pixelIdxT winQueryPixel,
    input  sampleT   queryLow,
    output peakT     winUpdate,
    output logic     winUpdValid,
    output resultT   result,
    output logic     resValid,
    input  logic     resReady
);

    localparam int Half = (1 << `SIFH_NB) / 2;

    sampleT coarseCentre;
    sampleT position;

    // both peaks are taken together and only into a free result slot
    assign peakReady     = coarseValid && fineValid && (!resValid || resReady);
    assign winQueryPixel = coarsePeak.pixel;

    assign coarseCentre = (sampleT'(coarsePeak.bin) << (`SIFH_NP - `SIFH_NB)) + sampleT'(Half);
    assign position     = (finePeak.count != '0) ? queryLow + sampleT'(finePeak.bin)
                                                 : coarseCentre;   // empty fine window

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resValid    <= 1'b0;
            winUpdValid <= 1'b0;
        end else begin
            winUpdValid <= peakReady;
            if (peakReady) begin
                resValid <= 1'b1;
            end else if (resReady) begin
                resValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (peakReady) begin
            result.pixel       <= coarsePeak.pixel;
            result.coarseBin   <= coarsePeak.bin;
            result.coarseCount <= coarsePeak.count;
            result.fineBin     <= finePeak.bin;
            result.fineCount   <= finePeak.count;
            result.windowLow   <= queryLow;
            result.position    <= position;
            winUpdate          <= coarsePeak;   // moves this pixel's window
        end
    end

    // banks must stay in lock step on pixels
    pixelsAligned: assert property (@(posedge clk) disable iff (!combin_res)
        coarseValid && fineValid |-> coarsePeak.pixel == finePeak.pixel);

endmodule

/* sifhPeakFinder.sv */
`timescale 1ns/1ps

module sifhPeakFinder import sifhHistoPkg::*, sifhStreamPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  sampleInT in,
    input  logic     inValid,
    output logic     inReady,
    output resultT   result,
    output logic     resValid,
    input  logic     resReady
);

    binEventT coarseEvt, fineRaw, fineEvt;
    logic     evtValid, coarseReady, fineReady;
    peakT     coarsePeak, finePeak, winUpdate;
    logic     coarseValid, fineValid, peakReady, winUpdValid;
    pixelIdxT winQueryPixel;
    sampleT   queryLow;

    sampleSequencer sequencer (
        .clk, .combin_res, .in, .inValid, .inReady,
        .coarseReady, .fineReady, .coarseEvt, .fineRaw, .evtValid
    );

    fineWindowMapper windowMapper (
        .clk, .combin_res, .fineRaw, .fineEvt,
        .winUpdate, .winUpdValid, .winQueryPixel, .queryLow
    );

    histogramBank coarseBank (
        .clk, .combin_res, .evt(coarseEvt), .evtValid, .ready(coarseReady),
        .peak(coarsePeak), .peakValid(coarseValid), .peakReady
    );

    histogramBank fineBank (
        .clk, .combin_res, .evt(fineEvt), .evtValid, .ready(fineReady),
        .peak(finePeak), .peakValid(fineValid), .peakReady
    );

    peakCombiner combiner (
        .clk, .combin_res, .coarsePeak, .finePeak, .coarseValid, .fineValid, .peakReady,
        .winQueryPixel, .queryLow, .winUpdate, .winUpdValid, .result, .resValid, .resReady
    );

endmodule

/* sifhPeakChecker.sv */
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhPeakChecker import sifhHistoPkg::*, sifhStreamPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  sampleInT in,
    input  logic     inValid,
    input  logic     inReady,
    input  resultT   result,
    input  logic     resValid,
    input  logic     resReady,
    output int       errCount,
    output int       resCount
);

    localparam int BinNum = 1 << `SIFH_NB;
    localparam int Shift  = `SIFH_NP - `SIFH_NB;
    localparam int MaxLow = (1 << `SIFH_NP) - BinNum;

    sampleT pixSamples [`SIFH_DATA_NUM];   // samples of the pixel being filled
    sampleT window [`SIFH_PIXEL_NUM];      // model window start per pixel
    resultT expected [$];
    int     sampleIdx  = 0;
    int     curPixel   = 0;
    int     errors     = 0;
    int     results    = 0;
    logic   firstCycle = 1'b0;

    assign errCount = errors;
    assign resCount = results;

    // both histograms of one pixel where the first bin to reach the max wins
    function automatic resultT predictResult(input int pixel);
        int     coarseHist [BinNum];
        int     fineHist [BinNum];
        int     cMax;
        int     cBin;
        int     fMax;
        int     fBin;
        int     b;
        int     off;
        resultT r;
        cMax = 0;
        cBin = 0;
        fMax = 0;
        fBin = 0;
        for (int i = 0; i < BinNum; i++) begin
            coarseHist[i] = 0;
            fineHist[i]   = 0;
        end
        for (int i = 0; i < `SIFH_DATA_NUM; i++) begin
            b = int'(pixSamples[i]) >> Shift;
            coarseHist[b]++;
            if (coarseHist[b] > cMax) begin
                cMax = coarseHist[b];
                cBin = b;
            end
            off = int'(pixSamples[i]) - int'(window[pixel]);
            if (off >= 0 && off < BinNum) begin   // outside the window is dropped
                fineHist[off]++;
                if (fineHist[off] > fMax) begin
                    fMax = fineHist[off];
                    fBin = off;
                end
            end
        end
        r.pixel       = pixelIdxT'(pixel);
        r.coarseBin   = binIdxT'(cBin);
        r.coarseCount = countT'(cMax);
        r.fineBin     = binIdxT'(fBin);
        r.fineCount   = countT'(fMax);
        r.windowLow   = window[pixel];
        if (fMax != 0) begin
            r.position = sampleT'(int'(window[pixel]) + fBin);
        end else begin
            r.position = sampleT'((cBin << Shift) + BinNum / 2);   // coarse centre
        end
        return r;
    endfunction

    function automatic sampleT nextWindow(input int coarseBin);
        int start;
        start = (coarseBin << Shift) + BinNum / 2 - BinNum / 2;   // centre less half a window
        if (start < 0) begin
            start = 0;
        end else if (start > MaxLow) begin
            start = MaxLow;
        end
        return sampleT'(start);
    endfunction

    task automatic compareField(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error: result %0d %s got %h expected %h", results, name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        resultT expRes;
        if (!combin_res) begin
            sampleIdx  = 0;
            curPixel   = 0;
            firstCycle = 1'b1;
            for (int i = 0; i < `SIFH_PIXEL_NUM; i++) begin
                window[i] = '0;
            end
            expected.delete();
        end else begin
            if (firstCycle && (inReady || resValid)) begin
                $display("inReady or resValid was high in the first cycle after reset");
                errors++;
            end
            firstCycle = 1'b0;
            if (inValid && inReady) begin
                pixSamples[sampleIdx] = in.value;
                if (sampleIdx == `SIFH_DATA_NUM - 1) begin
                    expRes = predictResult(curPixel);
                    expected.push_back(expRes);
                    window[curPixel] = nextWindow(expRes.coarseBin);   // used next frame
                    sampleIdx = 0;
                    curPixel  = (curPixel + 1) % `SIFH_PIXEL_NUM;
                end else begin
                    sampleIdx++;
                end
            end
            if (resValid && resReady) begin
                if (expected.size() == 0) begin
                    $display("a result came out before any pixel was complete for it");
                    errors++;
                end else begin
                    expRes = expected.pop_front();
                    compareField("pixel", result.pixel, expRes.pixel);
                    compareField("coarseBin", result.coarseBin, expRes.coarseBin);
                    compareField("coarseCount", result.coarseCount, expRes.coarseCount);
                    compareField("fineBin", result.fineBin, expRes.fineBin);
                    compareField("fineCount", result.fineCount, expRes.fineCount);
                    compareField("windowLow", result.windowLow, expRes.windowLow);
                    compareField("position", result.position, expRes.position);
                end
                results++;
            end
        end
    end

endmodule

/* sifhPeakFinderTb.sv */
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhPeakFinderTb import sifhHistoPkg::*, sifhStreamPkg::*; ();

    localparam int FrameNum       = 6;
    localparam int SampleNum      = FrameNum * `SIFH_DATA_NUM * `SIFH_PIXEL_NUM;
    localparam int ResultNum      = FrameNum * `SIFH_PIXEL_NUM;
    localparam int WatchdogCycles = SampleNum * 4 + 200;

    logic        clk;
    logic        combin_res;
    sampleInT    in;
    logic        inValid;
    logic        inReady;
    resultT      result;
    logic        resValid;
    logic        resReady;
    logic        taken;          // sample accepted at the last rising edge
    int          errCount;
    int          resCount;
    int          totalErrors;
    int          nextIdx;
    int          stallLeft;      // cycles left in a long resReady stall
    logic [31:0] lfsr;
    logic [31:0] bits;
    sampleT      nextValue;
    sampleT      centre [`SIFH_PIXEL_NUM];

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // lower half of the pixels clusters around its own centre
    task automatic makeSample(input int idx, output sampleT v);
        int          pixel;
        logic [31:0] r;
        pixel = (idx / `SIFH_DATA_NUM) % `SIFH_PIXEL_NUM;
        if (pixel < `SIFH_PIXEL_NUM / 2) begin
            drawBits(3, r);
            v = centre[pixel] + sampleT'(r) - sampleT'(4);
        end else begin
            drawBits(`SIFH_NP, r);
            v = sampleT'(r);
        end
    endtask

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        taken <= inValid && inReady;
    end

    sifhPeakFinder sifhPeakFinder_inst (
        .clk, .combin_res, .in, .inValid, .inReady, .result, .resValid, .resReady
    );

    sifhPeakChecker peakChecker (
        .clk, .combin_res, .in, .inValid, .inReady, .result, .resValid, .resReady,
        .errCount, .resCount
    );

    initial begin
        lfsr       = 32'h31d7d291;
        combin_res = 1'b0;
        in         = '0;
        inValid    = 1'b0;
        resReady   = 1'b0;
        nextIdx    = 0;
        stallLeft  = 0;
        for (int p = 0; p < `SIFH_PIXEL_NUM; p++) begin
            drawBits(`SIFH_NP, bits);
            centre[p] = sampleT'(bits);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
        while (nextIdx < SampleNum || inValid || resCount < ResultNum) begin
            @(negedge clk);
            if (stallLeft > 0) begin
                resReady = 1'b0;
                stallLeft--;
            end else begin
                drawBits(5, bits);
                if (bits[4:0] == 5'd0) begin
                    drawBits(4, bits);
                    stallLeft = 24 + int'(bits[3:0]);   // long enough to fill both peak slots
                    resReady  = 1'b0;
                end else begin
                    drawBits(2, bits);
                    resReady = (bits[1:0] != 2'b00);   // short stall one cycle in four
                end
            end
            if (inValid && taken) begin
                inValid = 1'b0;
            end
            if (!inValid && nextIdx < SampleNum) begin
                drawBits(2, bits);
                if (bits[1:0] != 2'b00) begin
                    makeSample(nextIdx, nextValue);
                    in.value = nextValue;
                    inValid  = 1'b1;
                    nextIdx++;
                end
            end
        end
        resReady = 1'b1;
        repeat (10) @(negedge clk);   // a duplicate result would show up here
        totalErrors = errCount;
        if (resCount != ResultNum) begin
            $display("got %0d results where %0d were expected", resCount, ResultNum);
            totalErrors++;
        end
        $display("closing: %0d results, %0d errors", resCount, totalErrors);
        if (totalErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d results received",
                 WatchdogCycles, resCount, ResultNum);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* sifhPeakFinder.f */
+incdir+.
sifhHistoPkg.sv
sifhStreamPkg.sv
sampleSequencer.sv
fineWindowMapper.sv
histogramBank.sv
peakCombiner.sv
sifhPeakFinder.sv
sifhPeakChecker.sv
sifhPeakFinderTb.sv

/* Bender.yml */
package:
  name: sifh_peak_finder

sources:
  - include_dirs:
      - .
    files:
      - sifhHistoPkg.sv
      - sifhStreamPkg.sv
      - sampleSequencer.sv
      - fineWindowMapper.sv
      - histogramBank.sv
      - peakCombiner.sv
      - sifhPeakFinder.sv
  - target: test
    include_dirs:
      - .
    files:
      - sifhPeakChecker.sv
      - sifhPeakFinderTb.sv
